// ==== design/pinmux_pkg.sv ====
package pinmux_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int PAD_W     = 38;
  localparam int GPIO_W    = 32;
  localparam int PORT_W    = 8;
  localparam int STRAP_W   = 16;
  localparam int PWM_N     = 6;
  localparam int UART_N    = 2;
  localparam int INTR_N    = 2;
  localparam int SPIM_CS_N = 4;
  localparam int WS_N      = 4;
  localparam int FLASH_W   = 4;

  // Multi-function select word fields
  localparam int FSEL_PWM_LSB  = 0;
  localparam int FSEL_INT_LSB  = 6;
  localparam int FSEL_UART_LSB = 8;
  localparam int FSEL_SPIM_BIT = 10;
  localparam int FSEL_CS_LSB   = 11;

  // Serial flash pad block: sck, 4 selects, 4 data
  localparam int FLASH_SCK_PAD = 28;
  localparam int FLASH_SS_PAD  = 29;
  localparam int FLASH_IO_PAD  = 33;

  // Strap bits come from two groups of PORT_W pads
  localparam int STRAP_LO_PAD = 13;
  localparam int STRAP_HI_PAD = 29;

  typedef enum logic [3:0] {
    FUNC_IN, FUNC_GPIO, FUNC_WS, FUNC_PWM, FUNC_UART_TX, FUNC_UART_RX,
    FUNC_INTR, FUNC_SPIM_CS, FUNC_SPIM_OUT, FUNC_SPIM_IN, FUNC_FLASH_OUT,
    FUNC_FLASH_IO
  } pad_func_e;

  typedef pad_func_e [PAD_W-1:0] pad_func_t;
  typedef logic [PAD_W-1:0] pad_vec_t;
  typedef logic [GPIO_W-1:0] gpio_vec_t;

  // ------------------------------
  // Pad mapping tables, -1 is none
  // ------------------------------
  localparam int PAD_GPIO_IDX [PAD_W] = '{
    0, 1, 2, 3, 4,                      // Port A 0-4
    22, 24, 25, 26, 27, 28,             // PC6, PD0-PD4
    14, 15,                             // PB6, PB7
    29, 30, 31,                         // PD5-PD7
    8, 9, 10, 11, 12, 13,               // PB0-PB5
    16, 17, 18, 19, 20, 21,             // PC0-PC5
    -1, -1, -1, -1, -1, -1, -1, -1, -1, -1
  };

  // Four pads per WS channel, pads 5 to 20
  localparam int PAD_WS_CH [PAD_W] = '{
    -1, -1, -1, -1, -1, 0, 0, 0, 0, 1,
    1, 1, 1, 2, 2, 2, 2, 3, 3, 3,
    3, -1, -1, -1, -1, -1, -1, -1, -1, -1,
    -1, -1, -1, -1, -1, -1, -1, -1
  };

  localparam int PAD_PWM_CH [PAD_W] = '{
    -1, -1, -1, -1, -1, -1, -1, -1, -1, 0,
    -1, -1, -1, 1, 2, -1, -1, 3, 4, 5,
    -1, -1, -1, -1, -1, -1, -1, -1, -1, -1,
    -1, -1, -1, -1, -1, -1, -1, -1
  };

  // Chip selects share the PWM pads, in reverse order
  localparam int PAD_CS_CH [PAD_W] = '{
    -1, -1, -1, -1, -1, -1, -1, -1, -1, -1,
    -1, -1, -1, 3, 2, -1, -1, 1, 0, -1,
    -1, -1, -1, -1, -1, -1, -1, -1, -1, -1,
    -1, -1, -1, -1, -1, -1, -1, -1
  };

  // Pads 13-20 and 28-37
  localparam pad_vec_t STRAP_PADS = 38'h3F_F01F_E000;

  // Pick bit idx of a vector, 0 when idx is none
  function automatic logic map_bit(input int idx, input gpio_vec_t vec);
    logic bit_v;
    bit_v = 1'b0;
    for (int i = 0; i < GPIO_W; i++) begin
      if (idx == i) begin
        bit_v = vec[i];
      end
    end
    return bit_v;
  endfunction

endpackage

// ==== design/pad_sync.sv ====
module pad_sync #(
  parameter type payload_t = logic
) (
  input  logic     mclk,
  input  logic     rst_n_i,
  input  payload_t async_i,
  output payload_t sync_o
);

  payload_t meta_q;
  payload_t sync_q;

  // Two stages against metastability on pad inputs
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      meta_q <= '0;
      sync_q <= '0;
    end else begin
      meta_q <= async_i;
      sync_q <= meta_q;
    end
  end

  assign sync_o = sync_q;

  // Exactly two edges of latency once out of reset
  a_sync_latency: assert property (@(posedge mclk) disable iff (!rst_n_i)
    $past(rst_n_i, 2) && $past(rst_n_i) |-> sync_o == $past(async_i, 2));

endmodule

// ==== design/strap_latch.sv ====
module strap_latch (
  input  logic                              mclk,
  input  logic                              rst_n_i,
  input  logic                              cfg_strap_pad_ctrl_i,
  input  pinmux_pkg::pad_vec_t              pad_in_i,
  output logic [pinmux_pkg::STRAP_W-1:0]    pad_strap_o
);

  import pinmux_pkg::*;

  logic [STRAP_W-1:0] strap_pads;

  // Upper byte from flash pads 36-29, lower from pads 20-13
  assign strap_pads = {pad_in_i[STRAP_HI_PAD +: PORT_W], pad_in_i[STRAP_LO_PAD +: PORT_W]};

  // Track pads while control is high, hold after it drops
  always_ff @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pad_strap_o <= '0;
    end else if (cfg_strap_pad_ctrl_i) begin
      pad_strap_o <= strap_pads;
    end
  end

  a_strap_hold: assert property (@(posedge mclk) disable iff (!rst_n_i)
    !cfg_strap_pad_ctrl_i |=> $stable(pad_strap_o));

  a_strap_capture: assert property (@(posedge mclk) disable iff (!rst_n_i)
    cfg_strap_pad_ctrl_i |=> pad_strap_o == $past(strap_pads));

endmodule

// ==== design/pad_func_sel.sv ====
module pad_func_sel (
  input  logic                      cfg_strap_pad_ctrl_i,
  input  pinmux_pkg::gpio_vec_t     cfg_gpio_out_type_i,
  input  pinmux_pkg::gpio_vec_t     cfg_gpio_dir_sel_i,
  input  logic [31:0]               cfg_multi_func_sel_i,
  output pinmux_pkg::pad_func_t     pad_func_o,
  output logic [pinmux_pkg::PWM_N-1:0] cfg_pwm_enb_o
);

  import pinmux_pkg::*;

  // ------------------------------
  // Config field decode
  // ------------------------------
  logic [PWM_N-1:0]     pwm_enb;
  logic [INTR_N-1:0]    int_enb;
  logic [UART_N-1:0]    uart_enb;
  logic                 spim_enb;
  logic [SPIM_CS_N-1:0] cs_enb;

  assign pwm_enb  = cfg_multi_func_sel_i[FSEL_PWM_LSB +: PWM_N];
  assign int_enb  = cfg_multi_func_sel_i[FSEL_INT_LSB +: INTR_N];
  assign uart_enb = cfg_multi_func_sel_i[FSEL_UART_LSB +: UART_N];
  assign spim_enb = cfg_multi_func_sel_i[FSEL_SPIM_BIT];
  assign cs_enb   = cfg_multi_func_sel_i[FSEL_CS_LSB +: SPIM_CS_N];

  // PWM block needs its enables too
  assign cfg_pwm_enb_o = pwm_enb;

  // ------------------------------
  // Per pad priority
  // ------------------------------
  always_comb begin
    logic      pwm_on;
    logic      cs_on;
    logic      ws_on;
    logic      dir_on;
    logic      periph_on;
    pad_func_e periph_f;
    for (int p = 0; p < PAD_W; p++) begin
      pwm_on = map_bit(PAD_PWM_CH[p], GPIO_W'(pwm_enb));
      cs_on  = map_bit(PAD_CS_CH[p], GPIO_W'(cs_enb));
      // WS type only counts on pads wired to a WS channel
      ws_on  = (PAD_WS_CH[p] >= 0) && map_bit(PAD_GPIO_IDX[p], cfg_gpio_out_type_i);
      dir_on = map_bit(PAD_GPIO_IDX[p], cfg_gpio_dir_sel_i);

      // Peripheral claims, ATmega pinout order
      periph_on = 1'b0;
      periph_f  = FUNC_IN;
      case (p)
        6, 7: begin
          periph_on = uart_enb[0];
          periph_f  = (p == 6) ? FUNC_UART_RX : FUNC_UART_TX;
        end
        8: begin
          // UART1 RX ahead of INT0
          periph_on = uart_enb[1] | int_enb[0];
          periph_f  = uart_enb[1] ? FUNC_UART_RX : FUNC_INTR;
        end
        9: begin
          periph_on = pwm_on | int_enb[1];
          periph_f  = pwm_on ? FUNC_PWM : FUNC_INTR;
        end
        10: begin
          periph_on = uart_enb[1];
          periph_f  = FUNC_UART_TX;
        end
        13, 14, 17, 18: begin
          periph_on = pwm_on | cs_on;
          periph_f  = pwm_on ? FUNC_PWM : FUNC_SPIM_CS;
        end
        19: begin
          // MISO in when SPI is on, else PWM5
          periph_on = spim_enb | pwm_on;
          periph_f  = spim_enb ? FUNC_SPIM_IN : FUNC_PWM;
        end
        20, 21: begin
          periph_on = spim_enb;
          periph_f  = FUNC_SPIM_OUT;
        end
        default: ;
      endcase

      if (cfg_strap_pad_ctrl_i && STRAP_PADS[p]) begin
        pad_func_o[p] = FUNC_IN;
      end else if (p >= FLASH_SCK_PAD && p < FLASH_IO_PAD) begin
        pad_func_o[p] = FUNC_FLASH_OUT;
      end else if (p >= FLASH_IO_PAD && p < FLASH_IO_PAD + FLASH_W) begin
        pad_func_o[p] = FUNC_FLASH_IO;
      end else if (periph_on) begin
        pad_func_o[p] = periph_f;
      end else if (ws_on) begin
        pad_func_o[p] = FUNC_WS;
      end else if (dir_on) begin
        pad_func_o[p] = FUNC_GPIO;
      end else begin
        pad_func_o[p] = FUNC_IN;
      end
    end
  end

endmodule

// ==== design/pad_drive_mux.sv ====
module pad_drive_mux (
  input  pinmux_pkg::pad_func_t             pad_func_i,
  input  pinmux_pkg::gpio_vec_t             pad_gpio_out_i,
  input  logic [pinmux_pkg::PWM_N-1:0]      pwm_wfm_i,
  input  logic [pinmux_pkg::UART_N-1:0]     uart_txd_i,
  input  logic [pinmux_pkg::WS_N-1:0]       ws_txd_i,
  input  logic                              spim_sck_i,
  input  logic [pinmux_pkg::SPIM_CS_N-1:0]  spim_ssn_i,
  input  logic                              spim_dout_i,
  input  logic                              sflash_sck_i,
  input  logic [pinmux_pkg::FLASH_W-1:0]    sflash_ss_i,
  input  logic [pinmux_pkg::FLASH_W-1:0]    sflash_do_i,
  input  logic [pinmux_pkg::FLASH_W-1:0]    sflash_oen_i,
  output pinmux_pkg::pad_vec_t              pad_out_o,
  output pinmux_pkg::pad_vec_t              pad_oen_o
);

  import pinmux_pkg::*;

  // ------------------------------
  // Output value per pad
  // ------------------------------
  always_comb begin
    for (int p = 0; p < PAD_W; p++) begin
      case (pad_func_i[p])
        FUNC_GPIO:     pad_out_o[p] = map_bit(PAD_GPIO_IDX[p], pad_gpio_out_i);
        FUNC_WS:       pad_out_o[p] = map_bit(PAD_WS_CH[p], GPIO_W'(ws_txd_i));
        FUNC_PWM:      pad_out_o[p] = map_bit(PAD_PWM_CH[p], GPIO_W'(pwm_wfm_i));
        // TXD0 on pad 7, TXD1 on pad 10
        FUNC_UART_TX:  pad_out_o[p] = (p == 10) ? uart_txd_i[1] : uart_txd_i[0];
        FUNC_SPIM_CS:  pad_out_o[p] = map_bit(PAD_CS_CH[p], GPIO_W'(spim_ssn_i));
        // SCK on pad 21, data out on pad 20
        FUNC_SPIM_OUT: pad_out_o[p] = (p == 21) ? spim_sck_i : spim_dout_i;
        FUNC_FLASH_OUT: begin
          pad_out_o[p] = (p == FLASH_SCK_PAD) ? sflash_sck_i
                       : map_bit(p - FLASH_SS_PAD, GPIO_W'(sflash_ss_i));
        end
        FUNC_FLASH_IO: pad_out_o[p] = map_bit(p - FLASH_IO_PAD, GPIO_W'(sflash_do_i));
        default:       pad_out_o[p] = 1'b0;
      endcase
    end
  end

  // ------------------------------
  // Output enable, active low
  // ------------------------------
  always_comb begin
    for (int p = 0; p < PAD_W; p++) begin
      case (pad_func_i[p])
        FUNC_IN, FUNC_UART_RX, FUNC_INTR, FUNC_SPIM_IN: pad_oen_o[p] = 1'b1;
        // Flash controller turns its own data pads around
        FUNC_FLASH_IO: pad_oen_o[p] = map_bit(p - FLASH_IO_PAD, GPIO_W'(sflash_oen_i));
        default:       pad_oen_o[p] = 1'b0;
      endcase
    end
  end

endmodule

// ==== design/pad_in_route.sv ====
module pad_in_route (
  input  pinmux_pkg::pad_func_t           pad_func_i,
  input  pinmux_pkg::pad_vec_t            pad_in_i,
  output pinmux_pkg::gpio_vec_t           gpio_raw_o,
  output logic [pinmux_pkg::INTR_N-1:0]   intr_raw_o,
  output logic [pinmux_pkg::UART_N-1:0]   uart_rxd_o,
  output logic                            spim_din_o,
  output logic [pinmux_pkg::FLASH_W-1:0]  sflash_di_o
);

  import pinmux_pkg::*;

  // GPIO bits see their pad whatever its function
  always_comb begin
    gpio_raw_o = '0;
    for (int g = 0; g < GPIO_W; g++) begin
      for (int p = 0; p < PAD_W; p++) begin
        if (PAD_GPIO_IDX[p] == g) begin
          gpio_raw_o[g] = pad_in_i[p];
        end
      end
    end
  end

  // ------------------------------
  // Peripheral inputs, idle unless owning pad has the code
  // ------------------------------
  always_comb begin
    uart_rxd_o = '1;
    intr_raw_o = '0;
    spim_din_o = 1'b0;
    if (pad_func_i[6] == FUNC_UART_RX) begin
      uart_rxd_o[0] = pad_in_i[6];
    end
    // Pad 8 is RXD1 or INT0, never both
    if (pad_func_i[8] == FUNC_UART_RX) begin
      uart_rxd_o[1] = pad_in_i[8];
    end
    if (pad_func_i[8] == FUNC_INTR) begin
      intr_raw_o[0] = pad_in_i[8];
    end
    if (pad_func_i[9] == FUNC_INTR) begin
      intr_raw_o[1] = pad_in_i[9];
    end
    if (pad_func_i[19] == FUNC_SPIM_IN) begin
      spim_din_o = pad_in_i[19];
    end
  end

  // Flash data in, straight from the IO pads
  assign sflash_di_o = pad_in_i[FLASH_IO_PAD +: FLASH_W];

endmodule

// ==== design/pinmux_top.sv ====
module pinmux_top (
  input  logic                              mclk,
  input  logic                              rst_n_i,
  // Configuration
  input  logic                              cfg_strap_pad_ctrl_i,
  input  pinmux_pkg::gpio_vec_t             cfg_gpio_out_type_i,
  input  pinmux_pkg::gpio_vec_t             cfg_gpio_dir_sel_i,
  input  logic [31:0]                       cfg_multi_func_sel_i,
  // Pads
  input  pinmux_pkg::pad_vec_t              pad_in_i,
  output pinmux_pkg::pad_vec_t              pad_out_o,
  output pinmux_pkg::pad_vec_t              pad_oen_o,
  // GPIO and simple peripherals
  input  pinmux_pkg::gpio_vec_t             pad_gpio_out_i,
  output pinmux_pkg::gpio_vec_t             pad_gpio_in_o,
  input  logic [pinmux_pkg::PWM_N-1:0]      pwm_wfm_i,
  output logic [pinmux_pkg::PWM_N-1:0]      cfg_pwm_enb_o,
  input  logic [pinmux_pkg::UART_N-1:0]     uart_txd_i,
  output logic [pinmux_pkg::UART_N-1:0]     uart_rxd_o,
  input  logic [pinmux_pkg::WS_N-1:0]       ws_txd_i,
  output logic [pinmux_pkg::INTR_N-1:0]     ext_intr_o,
  // SPI master
  input  logic                              spim_sck_i,
  input  logic [pinmux_pkg::SPIM_CS_N-1:0]  spim_ssn_i,
  input  logic                              spim_dout_i,
  output logic                              spim_din_o,
  // Serial flash
  input  logic                              sflash_sck_i,
  input  logic [pinmux_pkg::FLASH_W-1:0]    sflash_ss_i,
  input  logic [pinmux_pkg::FLASH_W-1:0]    sflash_do_i,
  input  logic [pinmux_pkg::FLASH_W-1:0]    sflash_oen_i,
  output logic [pinmux_pkg::FLASH_W-1:0]    sflash_di_o,
  // Strap
  output logic [pinmux_pkg::STRAP_W-1:0]    pad_strap_o
);

  import pinmux_pkg::*;

  pad_func_t          pad_func;
  gpio_vec_t          gpio_raw;
  logic [INTR_N-1:0]  intr_raw;

  // ------------------------------
  // Combinational pad path
  // ------------------------------
  pad_func_sel u_func_sel (
    .cfg_strap_pad_ctrl_i (cfg_strap_pad_ctrl_i),
    .cfg_gpio_out_type_i  (cfg_gpio_out_type_i),
    .cfg_gpio_dir_sel_i   (cfg_gpio_dir_sel_i),
    .cfg_multi_func_sel_i (cfg_multi_func_sel_i),
    .pad_func_o           (pad_func),
    .cfg_pwm_enb_o        (cfg_pwm_enb_o)
  );

  pad_drive_mux u_drive_mux (
    .pad_func_i     (pad_func),
    .pad_gpio_out_i (pad_gpio_out_i),
    .pwm_wfm_i      (pwm_wfm_i),
    .uart_txd_i     (uart_txd_i),
    .ws_txd_i       (ws_txd_i),
    .spim_sck_i     (spim_sck_i),
    .spim_ssn_i     (spim_ssn_i),
    .spim_dout_i    (spim_dout_i),
    .sflash_sck_i   (sflash_sck_i),
    .sflash_ss_i    (sflash_ss_i),
    .sflash_do_i    (sflash_do_i),
    .sflash_oen_i   (sflash_oen_i),
    .pad_out_o      (pad_out_o),
    .pad_oen_o      (pad_oen_o)
  );

  pad_in_route u_in_route (
    .pad_func_i  (pad_func),
    .pad_in_i    (pad_in_i),
    .gpio_raw_o  (gpio_raw),
    .intr_raw_o  (intr_raw),
    .uart_rxd_o  (uart_rxd_o),
    .spim_din_o  (spim_din_o),
    .sflash_di_o (sflash_di_o)
  );

  // ------------------------------
  // Clocked pad inputs
  // ------------------------------
  pad_sync #(.payload_t(gpio_vec_t)) u_gpio_sync (
    .mclk    (mclk),
    .rst_n_i (rst_n_i),
    .async_i (gpio_raw),
    .sync_o  (pad_gpio_in_o)
  );

  pad_sync #(.payload_t(logic [INTR_N-1:0])) u_intr_sync (
    .mclk    (mclk),
    .rst_n_i (rst_n_i),
    .async_i (intr_raw),
    .sync_o  (ext_intr_o)
  );

  strap_latch u_strap_latch (
    .mclk                 (mclk),
    .rst_n_i              (rst_n_i),
    .cfg_strap_pad_ctrl_i (cfg_strap_pad_ctrl_i),
    .pad_in_i             (pad_in_i),
    .pad_strap_o          (pad_strap_o)
  );

endmodule

// ==== verif/tb_pinmux.sv ====
module tb_pinmux;

  import pinmux_pkg::*;

  logic                 mclk;
  logic                 rst_n_i;
  logic                 cfg_strap_pad_ctrl_i;
  gpio_vec_t            cfg_gpio_out_type_i;
  gpio_vec_t            cfg_gpio_dir_sel_i;
  logic [31:0]          cfg_multi_func_sel_i;
  pad_vec_t             pad_in_i;
  gpio_vec_t            pad_gpio_out_i;
  logic [PWM_N-1:0]     pwm_wfm_i;
  logic [UART_N-1:0]    uart_txd_i;
  logic [WS_N-1:0]      ws_txd_i;
  logic                 spim_sck_i;
  logic [SPIM_CS_N-1:0] spim_ssn_i;
  logic                 spim_dout_i;
  logic                 sflash_sck_i;
  logic [FLASH_W-1:0]   sflash_ss_i;
  logic [FLASH_W-1:0]   sflash_do_i;
  logic [FLASH_W-1:0]   sflash_oen_i;
  pad_vec_t             pad_out_o;
  pad_vec_t             pad_oen_o;
  gpio_vec_t            pad_gpio_in_o;
  logic [PWM_N-1:0]     cfg_pwm_enb_o;
  logic [UART_N-1:0]    uart_rxd_o;
  logic [INTR_N-1:0]    ext_intr_o;
  logic                 spim_din_o;
  logic [FLASH_W-1:0]   sflash_di_o;
  logic [STRAP_W-1:0]   pad_strap_o;

  // Reference model outputs
  pad_vec_t             exp_out;
  pad_vec_t             exp_oen;
  gpio_vec_t            exp_gpio_raw;
  logic [INTR_N-1:0]    exp_intr_raw;
  logic [UART_N-1:0]    exp_rxd;
  logic                 exp_din;
  logic [STRAP_W-1:0]   exp_strap;
  int                   run_cnt;

  pinmux_top UUT (.*);

  initial begin
    mclk = 1'b0;
    forever #20 mclk = ~mclk;
  end

  // Cycles since reset release, saturating
  always @(posedge mclk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_cnt <= 0;
    end else if (run_cnt < 3) begin
      run_cnt <= run_cnt + 1;
    end
  end

  // Bit idx of vec, 0 for a pad with no mapping
  function automatic logic bit_of(input logic [31:0] vec, input int idx);
    logic [31:0] shifted;
    if (idx < 0) begin
      return 1'b0;
    end
    shifted = vec >> idx;
    return shifted[0];
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  always_comb begin
    logic [PWM_N-1:0]  pwm_en;
    logic [INTR_N-1:0] int_en;
    logic [UART_N-1:0] uart_en;
    logic              spi_en;
    logic              pwm_hit;
    logic              cs_hit;
    logic              taken;
    logic              val;
    logic              oen_v;
    int                g;
    int                w;
    int                c;
    int                k;
    pwm_en  = cfg_multi_func_sel_i[FSEL_PWM_LSB +: PWM_N];
    int_en  = cfg_multi_func_sel_i[FSEL_INT_LSB +: INTR_N];
    uart_en = cfg_multi_func_sel_i[FSEL_UART_LSB +: UART_N];
    spi_en  = cfg_multi_func_sel_i[FSEL_SPIM_BIT];
    exp_gpio_raw = '0;
    for (int p = 0; p < PAD_W; p++) begin
      g = PAD_GPIO_IDX[p];
      w = PAD_WS_CH[p];
      c = PAD_PWM_CH[p];
      k = PAD_CS_CH[p];
      pwm_hit = bit_of(32'(pwm_en), c);
      cs_hit  = bit_of(cfg_multi_func_sel_i >> FSEL_CS_LSB, k);
      val   = 1'b0;
      oen_v = 1'b1;
      taken = 1'b0;
      // Strap control first, then flash block, then peripherals
      if (cfg_strap_pad_ctrl_i && STRAP_PADS[p]) begin
        taken = 1'b1;
      end else if (p >= 28 && p <= 32) begin
        taken = 1'b1;
        oen_v = 1'b0;
        val   = (p == 28) ? sflash_sck_i : bit_of(32'(sflash_ss_i), p - 29);
      end else if (p >= 33 && p <= 36) begin
        taken = 1'b1;
        oen_v = bit_of(32'(sflash_oen_i), p - 33);
        val   = bit_of(32'(sflash_do_i), p - 33);
      end else begin
        case (p)
          6: taken = uart_en[0];
          7: begin
            taken = uart_en[0];
            val   = uart_txd_i[0];
          end
          8: taken = uart_en[1] | int_en[0];
          9: begin
            taken = pwm_hit | int_en[1];
            val   = pwm_hit ? bit_of(32'(pwm_wfm_i), c) : 1'b0;
            oen_v = !pwm_hit;
          end
          10: begin
            taken = uart_en[1];
            val   = uart_txd_i[1];
          end
          13, 14, 17, 18: begin
            taken = pwm_hit | cs_hit;
            val   = pwm_hit ? bit_of(32'(pwm_wfm_i), c) : bit_of(32'(spim_ssn_i), k);
          end
          19: begin
            // MISO is an input pad
            taken = spi_en | pwm_hit;
            val   = spi_en ? 1'b0 : bit_of(32'(pwm_wfm_i), c);
            oen_v = spi_en || !pwm_hit;
          end
          20: begin
            taken = spi_en;
            val   = spim_dout_i;
          end
          21: begin
            taken = spi_en;
            val   = spim_sck_i;
          end
          default: taken = 1'b0;
        endcase
        // Output pads of a claim drive, input claims keep oen high
        if (taken && p != 6 && p != 8 && p != 9 && p != 19) begin
          oen_v = 1'b0;
        end
        if (!taken) begin
          val = 1'b0;
        end
      end
      if (!taken && w >= 0 && bit_of(cfg_gpio_out_type_i, g)) begin
        oen_v = 1'b0;
        val   = bit_of(32'(ws_txd_i), w);
      end else if (!taken && bit_of(cfg_gpio_dir_sel_i, g)) begin
        oen_v = 1'b0;
        val   = bit_of(pad_gpio_out_i, g);
      end
      exp_out[p] = val;
      exp_oen[p] = oen_v;
      if (g >= 0) begin
        exp_gpio_raw[g[4:0]] = pad_in_i[p];
      end
    end
    exp_rxd[0]      = uart_en[0] ? pad_in_i[6] : 1'b1;
    exp_rxd[1]      = uart_en[1] ? pad_in_i[8] : 1'b1;
    exp_intr_raw[0] = (int_en[0] && !uart_en[1]) ? pad_in_i[8] : 1'b0;
    exp_intr_raw[1] = (int_en[1] && !pwm_en[0]) ? pad_in_i[9] : 1'b0;
    exp_din         = (spi_en && !cfg_strap_pad_ctrl_i) ? pad_in_i[19] : 1'b0;
    exp_strap       = {pad_in_i[36:29], pad_in_i[20:13]};
  end

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  // ------------------------------
  // Checks against the model
  // ------------------------------
  a_reset_zero: assert property (@(posedge mclk) run_cnt == 0 |->
    pad_gpio_in_o == '0 && ext_intr_o == '0 && pad_strap_o == '0)
    else report_mismatch("registered outputs not 0 around reset");
  a_pad_out: assert property (@(posedge mclk) pad_out_o == exp_out)
    else report_mismatch("pad_out_o differs from model");
  a_pad_oen: assert property (@(posedge mclk) pad_oen_o == exp_oen)
    else report_mismatch("pad_oen_o differs from model");
  a_strap_oen: assert property (@(posedge mclk)
    cfg_strap_pad_ctrl_i |-> (pad_oen_o & STRAP_PADS) == STRAP_PADS)
    else report_mismatch("strap pad driven while strap control high");
  a_uart_rxd: assert property (@(posedge mclk) uart_rxd_o == exp_rxd)
    else report_mismatch("uart_rxd_o differs from model");
  a_spim_din: assert property (@(posedge mclk) spim_din_o == exp_din)
    else report_mismatch("spim_din_o differs from model");
  a_flash_di: assert property (@(posedge mclk) sflash_di_o == pad_in_i[36:33])
    else report_mismatch("sflash_di_o does not mirror pads 33 to 36");
  a_pwm_enb: assert property (@(posedge mclk)
    cfg_pwm_enb_o == cfg_multi_func_sel_i[FSEL_PWM_LSB +: PWM_N])
    else report_mismatch("cfg_pwm_enb_o differs from select word");
  a_gpio_sync: assert property (@(posedge mclk) disable iff (!rst_n_i)
    run_cnt >= 2 |-> pad_gpio_in_o == $past(exp_gpio_raw, 2))
    else report_mismatch("pad_gpio_in_o not pad bits from 2 edges earlier");
  a_intr_sync: assert property (@(posedge mclk) disable iff (!rst_n_i)
    run_cnt >= 2 |-> ext_intr_o == $past(exp_intr_raw, 2))
    else report_mismatch("ext_intr_o not interrupt pads from 2 edges earlier");
  a_strap_follow: assert property (@(posedge mclk) disable iff (!rst_n_i)
    run_cnt >= 1 && $past(cfg_strap_pad_ctrl_i) |-> pad_strap_o == $past(exp_strap))
    else report_mismatch("pad_strap_o missed strap pads while control high");
  a_strap_hold: assert property (@(posedge mclk) disable iff (!rst_n_i)
    run_cnt >= 1 && !$past(cfg_strap_pad_ctrl_i) |-> pad_strap_o == $past(pad_strap_o))
    else report_mismatch("pad_strap_o changed while control low");

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic drive_cycle(input logic [31:0] fsel, input logic strap_ctrl);
    logic [31:0] r;
    logic [63:0] pads;
    @(posedge mclk);
    r    = $urandom();
    pads = {$urandom(), $urandom()};
    cfg_multi_func_sel_i <= fsel;
    cfg_strap_pad_ctrl_i <= strap_ctrl;
    cfg_gpio_dir_sel_i   <= $urandom();
    cfg_gpio_out_type_i  <= $urandom();
    pad_gpio_out_i       <= $urandom();
    pad_in_i             <= pads[PAD_W-1:0];
    pwm_wfm_i            <= r[5:0];
    uart_txd_i           <= r[7:6];
    ws_txd_i             <= r[11:8];
    spim_sck_i           <= r[12];
    spim_ssn_i           <= r[16:13];
    spim_dout_i          <= r[17];
    sflash_sck_i         <= r[18];
    sflash_ss_i          <= r[22:19];
    sflash_do_i          <= r[26:23];
    sflash_oen_i         <= r[30:27];
  endtask

  // Select word is random under mask, then forced bits OR'd in
  task automatic run_phase(input int cycles, input logic [31:0] mask,
                           input logic [31:0] force_bits, input logic strap_ctrl);
    for (int i = 0; i < cycles; i++) begin
      drive_cycle(($urandom() & mask) | force_bits, strap_ctrl);
    end
  endtask

  task automatic wait_run_cycles(input int need, input int max_cycles);
    int waited;
    waited = 0;
    while (run_cnt < need) begin
      @(posedge mclk);
      waited++;
      if (waited > max_cycles) begin
        $display("Timeout waiting for the DUT to leave reset");
        $display("Test failed");
        $fatal(1, "reset release timeout");
      end
    end
  endtask

  initial begin
    logic [31:0] int_bits;
    logic [31:0] all_fsel;
    void'($urandom(88));
    int_bits = 32'h3 << FSEL_INT_LSB;
    all_fsel = (32'h1 << (FSEL_CS_LSB + SPIM_CS_N)) - 32'h1;
    rst_n_i              <= 1'b0;
    cfg_strap_pad_ctrl_i <= 1'b0;
    cfg_gpio_out_type_i  <= '0;
    cfg_gpio_dir_sel_i   <= '0;
    cfg_multi_func_sel_i <= '0;
    pad_in_i             <= '0;
    pad_gpio_out_i       <= '0;
    pwm_wfm_i            <= '0;
    uart_txd_i           <= '1;
    ws_txd_i             <= '0;
    spim_sck_i           <= 1'b0;
    spim_ssn_i           <= '1;
    spim_dout_i          <= 1'b0;
    sflash_sck_i         <= 1'b0;
    sflash_ss_i          <= '1;
    sflash_do_i          <= '0;
    sflash_oen_i         <= '1;
    // Pads keep toggling through reset
    run_phase(10, 32'h0, 32'h0, 1'b0);
    rst_n_i <= 1'b1;
    wait_run_cycles(2, 20);
    // GPIO and WS only, then random peripheral enables
    run_phase(200, 32'h0, 32'h0, 1'b0);
    run_phase(300, all_fsel, 32'h0, 1'b0);
    // INT forced on, UART1 and PWM0 still contend for pads 8 and 9
    run_phase(200, all_fsel & ~int_bits, int_bits, 1'b0);
    run_phase(100, all_fsel & ~int_bits, 32'h0, 1'b0);
    // Strap capture window, then hold
    run_phase(200, all_fsel, 32'h0, 1'b1);
    run_phase(200, all_fsel, 32'h0, 1'b0);
    run_phase(100, 32'h0, 32'h0, 1'b0);
    for (int i = 0; i < 3; i++) begin
      @(posedge mclk);
    end
    $display("Test passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
design/pinmux_pkg.sv
design/pad_sync.sv
design/strap_latch.sv
design/pad_func_sel.sv
design/pad_drive_mux.sv
design/pad_in_route.sv
design/pinmux_top.sv
verif/tb_pinmux.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_pinmux
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
